/* bench/conv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int WAIT_LIMIT   = 400;
    localparam int MAX_GAP      = 4;
    // Ignored beats stop well before busy falls at the end of a burst.
    localparam int JUNK_LAST    = conv_pkg::NUM_RESULTS - 10;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    conv_pkg::row_t    in_row;
    conv_pkg::kernel_t in_kernel;
    logic              out_valid;
    conv_pkg::result_t out_data;

    conv_pkg::row_t    ref_rows [conv_pkg::MAT_DIM];
    conv_pkg::kernel_t ref_kernels [conv_pkg::NUM_KERNELS];
    int                expected_q [$];
    int                cyc = 0;
    int                sixth_edge;
    logic              load_started;
    string             test_name;

    conv_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_row    (in_row),
        .in_kernel (in_kernel),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Rising edge count; read at a falling edge it names the edge just passed.
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic end_in_failure();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
        end_in_failure();
    endtask

    task automatic report_problem(input string what);
        $display("[ERROR] %s", what);
        end_in_failure();
    endtask

    function automatic int elem_at(input conv_pkg::row_t row, input int c);
        return int'(row[c*conv_pkg::ELEM_W +: conv_pkg::ELEM_W]);
    endfunction

    function automatic int tap_at(input conv_pkg::kernel_t kernel, input int t);
        return int'(kernel[t*conv_pkg::ELEM_W +: conv_pkg::ELEM_W]);
    endfunction

    // Weighted sum of the 2x2 window at (r,c) with kernel k.
    function automatic int window_sum(input int k, input int r, input int c);
        return elem_at(ref_rows[r], c) * tap_at(ref_kernels[k], 0)
             + elem_at(ref_rows[r], c + 1) * tap_at(ref_kernels[k], 1)
             + elem_at(ref_rows[r + 1], c) * tap_at(ref_kernels[k], 2)
             + elem_at(ref_rows[r + 1], c + 1) * tap_at(ref_kernels[k], 3);
    endfunction

    function automatic void build_expected();
        for (int k = 0; k < conv_pkg::NUM_KERNELS; k++) begin
            for (int r = 0; r < conv_pkg::WIN_SPAN; r++) begin
                for (int c = 0; c < conv_pkg::WIN_SPAN; c++) begin
                    expected_q.push_back(window_sum(k, r, c));
                end
            end
        end
    endfunction

    task automatic fill_random();
        for (int i = 0; i < conv_pkg::MAT_DIM; i++) begin
            ref_rows[i] = conv_pkg::row_t'($urandom);
        end
        for (int i = 0; i < conv_pkg::NUM_KERNELS; i++) begin
            ref_kernels[i] = conv_pkg::kernel_t'($urandom);
        end
    endtask

    task automatic fill_uniform(input conv_pkg::row_t row_val, input conv_pkg::kernel_t kernel_val);
        for (int i = 0; i < conv_pkg::MAT_DIM; i++) begin
            ref_rows[i] = row_val;
        end
        for (int i = 0; i < conv_pkg::NUM_KERNELS; i++) begin
            ref_kernels[i] = kernel_val;
        end
    endtask

    // Idle beat with noise on the data lines.
    task automatic idle_cycle();
        @(negedge clk);
        in_valid  = 1'b0;
        in_row    = conv_pkg::row_t'($urandom);
        in_kernel = conv_pkg::kernel_t'($urandom);
    endtask

    // Beat carrying unrelated data that the DUT must drop.
    task automatic drive_junk();
        in_valid  = 1'b1;
        in_row    = conv_pkg::row_t'($urandom);
        in_kernel = conv_pkg::kernel_t'($urandom);
    endtask

    task automatic load_set(input int max_gap, input bit inject_junk);
        int gap;
        for (int b = 0; b < conv_pkg::LOAD_BEATS; b++) begin
            gap = $urandom_range(max_gap, 0);
            repeat (gap) idle_cycle();
            @(negedge clk);
            in_valid  = 1'b1;
            in_row    = ref_rows[b];
            in_kernel = ref_kernels[b];
            if (b == conv_pkg::LOAD_BEATS - 1) begin
                sixth_edge   = cyc + 1;
                load_started = 1'b1;
            end
        end
        // The beat right after the sixth lands while loaded is high.
        if (inject_junk) begin
            @(negedge clk);
            drive_junk();
        end else begin
            idle_cycle();
        end
    endtask

    task automatic wait_for_output();
        int waited;
        waited = 0;
        while (!out_valid) begin
            if (waited == WAIT_LIMIT) begin
                report_problem($sformatf("%s: out_valid did not rise within %0d cycles",
                                         test_name, WAIT_LIMIT));
            end
            @(negedge clk);
            waited++;
        end
        assert (cyc - sixth_edge == 2)
            else report_mismatch({test_name, " latency"}, 2, cyc - sixth_edge);
    endtask

    task automatic collect_results(input bit inject_junk);
        int expected;
        for (int i = 0; i < conv_pkg::NUM_RESULTS; i++) begin
            expected = expected_q.pop_front();
            assert (out_valid)
                else report_problem($sformatf("%s: out_valid fell after %0d results",
                                              test_name, i));
            assert (int'(out_data) == expected)
                else report_mismatch($sformatf("%s result %0d", test_name, i),
                                     expected, int'(out_data));
            // Beats sent mid-burst carry unrelated data and must be dropped.
            if (inject_junk && i < JUNK_LAST) begin
                drive_junk();
            end else begin
                in_valid = 1'b0;
            end
            @(negedge clk);
        end
        assert (!out_valid)
            else report_problem($sformatf("%s: out_valid stayed high past %0d results",
                                          test_name, conv_pkg::NUM_RESULTS));
        assert (out_data == '0)
            else report_mismatch({test_name, " data after burst"}, 0, int'(out_data));
    endtask

    task automatic run_load(input string name, input int max_gap, input bit inject_junk);
        test_name = name;
        build_expected();
        load_set(max_gap, inject_junk);
        wait_for_output();
        collect_results(inject_junk);
    endtask

    // Nothing leaves the DUT before the first set is loaded.
    a_quiet_before_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        !load_started |-> (!out_valid && out_data == '0)
    ) else report_problem("out_valid or out_data active before the first load");

    a_idle_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !out_valid |-> (out_data == '0)
    ) else report_mismatch("idle output", 0, int'(out_data));

    initial begin
        void'($urandom(60));
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        in_row       = '0;
        in_kernel    = '0;
        load_started = 1'b0;
        sixth_edge   = 0;
        test_name    = "reset";

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!out_valid && out_data == '0)
                else report_problem("out_valid or out_data active during reset");
        end
        rst_n = 1'b1;
        repeat (3) idle_cycle();

        fill_random();
        run_load("random consecutive", 0, 1'b0);
        fill_random();
        run_load("random back to back", 0, 1'b0);
        fill_random();
        run_load("gapped", MAX_GAP, 1'b0);
        fill_random();
        run_load("gapped again", MAX_GAP, 1'b0);
        fill_random();
        run_load("ignored beats", 0, 1'b1);
        fill_random();
        run_load("after ignored beats", MAX_GAP, 1'b0);

        fill_uniform('1, '1);
        run_load("all sevens", 0, 1'b0);

        // Random matrix against a zero kernel bank.
        fill_random();
        for (int i = 0; i < conv_pkg::NUM_KERNELS; i++) begin
            ref_kernels[i] = '0;
        end
        run_load("zero kernels", 0, 1'b0);

        repeat (4) idle_cycle();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the convolution engine testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=conv_sim

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --assert -Wno-fatal --top-module conv_tb \
    -f tb.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation result: FAIL"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation result: PASS"
exit 0

/* src/conv_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_loader (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  conv_pkg::row_t         in_row,
    input  conv_pkg::kernel_t      in_kernel,
    input  logic                   busy,
    output conv_pkg::matrix_t      matrix,
    output conv_pkg::kernel_bank_t kernels,
    output logic                   loaded
);

    conv_pkg::idx_t beat_cnt;
    logic           accept;
    logic           last_beat;

    // Input is ignored while a burst runs or a set is being handed over.
    assign accept    = in_valid && !busy && !loaded;
    assign last_beat = (beat_cnt == conv_pkg::LAST_BEAT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            loaded   <= 1'b0;
        end else begin
            loaded <= accept && last_beat;
            if (accept) begin
                beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // Shift toward entry 0 so the first beat lands there after six.
    always_ff @(posedge clk) begin
        if (accept) begin
            matrix  <= {matrix[1:conv_pkg::MAT_DIM-1], in_row};
            kernels <= {kernels[1:conv_pkg::NUM_KERNELS-1], in_kernel};
        end
    end

    a_loaded_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        loaded |=> !loaded
    );

    a_beat_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        beat_cnt <= conv_pkg::LAST_BEAT
    );

endmodule

`default_nettype wire

/* src/conv_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_mac (
    input  logic                   clk,
    input  logic                   rst_n,
    input  conv_pkg::matrix_t      matrix,
    input  conv_pkg::kernel_bank_t kernels,
    input  conv_pkg::conv_pos_s    pos,
    input  logic                   pos_valid,
    output logic                   out_valid,
    output conv_pkg::result_t      out_data
);

    // Rows and kernels viewed as arrays of 3-bit fields, field 0 in the low bits.
    logic [conv_pkg::MAT_DIM-1:0][conv_pkg::ELEM_W-1:0]     row_top;
    logic [conv_pkg::MAT_DIM-1:0][conv_pkg::ELEM_W-1:0]     row_bot;
    logic [conv_pkg::KERNEL_TAPS-1:0][conv_pkg::ELEM_W-1:0] taps;
    logic [conv_pkg::KERNEL_TAPS-1:0][conv_pkg::ELEM_W-1:0] win;
    logic [conv_pkg::KERNEL_TAPS-1:0][2*conv_pkg::ELEM_W-1:0] prod;
    conv_pkg::idx_t    row_nxt;
    conv_pkg::idx_t    col_nxt;
    conv_pkg::result_t sum;

    assign row_nxt = pos.row + 1'b1;
    assign col_nxt = pos.col + 1'b1;

    assign row_top = matrix[pos.row];
    assign row_bot = matrix[row_nxt];
    assign taps    = kernels[pos.kidx];

    // Window element t pairs with tap t.
    assign win = {row_bot[col_nxt], row_bot[pos.col], row_top[col_nxt], row_top[pos.col]};

    always_comb begin
        sum = '0;
        for (int t = 0; t < conv_pkg::KERNEL_TAPS; t++) begin
            prod[t] = win[t] * taps[t];
            sum     = sum + conv_pkg::result_t'(prod[t]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= pos_valid;
            out_data  <= pos_valid ? sum : '0;
        end
    end

    a_idle_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !out_valid |-> (out_data == '0)
    );

endmodule

`default_nettype wire

/* src/conv_pkg.sv */
`default_nettype none

package conv_pkg;

    // One matrix element or kernel tap.
    localparam int ELEM_W      = 3;
    localparam int MAT_DIM     = 6;
    localparam int NUM_KERNELS = 6;
    localparam int KERNEL_TAPS = 4;

    // A 2x2 window fits in five positions along each axis.
    localparam int WIN_SPAN    = MAT_DIM - 1;

    localparam int ROW_W       = MAT_DIM * ELEM_W;
    localparam int KERNEL_W    = KERNEL_TAPS * ELEM_W;

    // Largest sum is 4 * 7 * 7 = 196.
    localparam int RESULT_W    = 8;
    localparam int NUM_RESULTS = NUM_KERNELS * WIN_SPAN * WIN_SPAN;
    localparam int LOAD_BEATS  = 6;

    // Width of the beat counter and of each position field.
    localparam int IDX_W       = 3;

    typedef logic [IDX_W-1:0] idx_t;

    localparam idx_t LAST_BEAT   = idx_t'(LOAD_BEATS - 1);
    localparam idx_t LAST_WIN    = idx_t'(WIN_SPAN - 1);
    localparam idx_t LAST_KERNEL = idx_t'(NUM_KERNELS - 1);

    typedef logic [ROW_W-1:0]    row_t;
    typedef logic [KERNEL_W-1:0] kernel_t;
    typedef logic [RESULT_W-1:0] result_t;

    // Index 0 holds the first row or kernel received.
    typedef row_t    [0:MAT_DIM-1]     matrix_t;
    typedef kernel_t [0:NUM_KERNELS-1] kernel_bank_t;

    // One issued window position.
    typedef struct packed {
        idx_t kidx;
        idx_t row;
        idx_t col;
    } conv_pos_s;

    typedef enum logic {
        IDLE    = 1'b0,
        COMPUTE = 1'b1
    } conv_state_e;

endpackage

`default_nettype wire

/* src/conv_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                loaded,
    output conv_pkg::conv_pos_s pos,
    output logic                pos_valid,
    output logic                busy
);

    conv_pkg::conv_state_e state_q;
    conv_pkg::conv_state_e state_d;
    conv_pkg::idx_t        kidx_q;
    conv_pkg::idx_t        row_q;
    conv_pkg::idx_t        col_q;
    logic                  col_last;
    logic                  row_last;
    logic                  kidx_last;
    logic                  issue_last;

    assign col_last   = (col_q == conv_pkg::LAST_WIN);
    assign row_last   = (row_q == conv_pkg::LAST_WIN);
    assign kidx_last  = (kidx_q == conv_pkg::LAST_KERNEL);
    assign issue_last = kidx_last && row_last && col_last;

    always_comb begin
        state_d = state_q;
        case (state_q)
            conv_pkg::IDLE: begin
                if (loaded) begin
                    state_d = conv_pkg::COMPUTE;
                end
            end
            conv_pkg::COMPUTE: begin
                if (issue_last) begin
                    state_d = conv_pkg::IDLE;
                end
            end
            default: state_d = conv_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= conv_pkg::IDLE;
            pos_valid <= 1'b0;
        end else begin
            state_q   <= state_d;
            pos_valid <= (state_d == conv_pkg::COMPUTE);
        end
    end

    // Column inner, kernel outer; all three wrap to zero after the last issue.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kidx_q <= '0;
            row_q  <= '0;
            col_q  <= '0;
        end else if (state_q == conv_pkg::COMPUTE) begin
            col_q <= col_last ? '0 : col_q + 1'b1;
            if (col_last) begin
                row_q <= row_last ? '0 : row_q + 1'b1;
                if (row_last) begin
                    kidx_q <= kidx_last ? '0 : kidx_q + 1'b1;
                end
            end
        end
    end

    assign pos  = '{kidx: kidx_q, row: row_q, col: col_q};
    assign busy = (state_q == conv_pkg::COMPUTE);

    a_win_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pos.row <= conv_pkg::LAST_WIN) && (pos.col <= conv_pkg::LAST_WIN)
    );

    a_kidx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        pos.kidx <= conv_pkg::LAST_KERNEL
    );

    a_valid_in_compute: assert property (
        @(posedge clk) disable iff (!rst_n)
        pos_valid |-> (state_q == conv_pkg::COMPUTE)
    );

endmodule

`default_nettype wire

/* src/conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  conv_pkg::row_t    in_row,
    input  conv_pkg::kernel_t in_kernel,
    output logic              out_valid,
    output conv_pkg::result_t out_data
);

    conv_pkg::matrix_t      matrix;
    conv_pkg::kernel_bank_t kernels;
    conv_pkg::conv_pos_s    pos;
    logic                   loaded;
    logic                   busy;
    logic                   pos_valid;

    conv_loader u_loader (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_row    (in_row),
        .in_kernel (in_kernel),
        .busy      (busy),
        .matrix    (matrix),
        .kernels   (kernels),
        .loaded    (loaded)
    );

    conv_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .loaded    (loaded),
        .pos       (pos),
        .pos_valid (pos_valid),
        .busy      (busy)
    );

    // Results leave straight from the MAC register.
    conv_mac u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .matrix    (matrix),
        .kernels   (kernels),
        .pos       (pos),
        .pos_valid (pos_valid),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

`default_nettype wire

/* tb.f */
src/conv_pkg.sv
src/conv_loader.sv
src/conv_sequencer.sv
src/conv_mac.sv
src/conv_top.sv
bench/conv_tb.sv
